// ==== structures.sv ====
package structures;

  // ##########################################################################
  // Widths
  // ##########################################################################

  localparam int xlen = 32;
  localparam int line_words = 4;

  typedef logic [line_words-1:0][xlen-1:0] line_t;  // One cache line

  typedef enum logic [1:0] {
    invalid,
    valid,
    modified
  } cache_state_e;

  typedef enum logic [1:0] {
    idle,
    fetch,
    install
  } miss_state_e;

  // ##########################################################################
  // Port bundles
  // ##########################################################################

  typedef struct packed {
    logic read;
    logic write;
    logic [xlen-1:0] address;
    logic [xlen-1:0] data;
  } cache_req_t;

  typedef struct packed {
    logic hit;
    logic [xlen-1:0] data;
  } cache_rsp_t;

  typedef struct packed {
    logic read;
    logic write;
    logic [xlen-1:0] address;  // Line aligned
    line_t line;
  } memory_req_t;

  typedef struct packed {
    logic ready;  // Read line present
    logic done;   // Write finished
    line_t line;
  } memory_rsp_t;

  typedef struct packed {
    logic [xlen-1:0] address;  // Line aligned
    line_t line;
  } wb_entry_t;

endpackage

// ==== write_buffer.sv ====
module write_buffer #(
  parameter int buffer_depth = 4
) (
  input  logic                        global_bus,
  input  logic                        reset,
  input  logic                        push,
  input  structures::wb_entry_t       push_entry,
  input  logic                        pop,
  input  logic [structures::xlen-1:0] lookup_address,
  output structures::wb_entry_t       head,
  output logic                        not_empty,
  output logic                        full,
  output logic                        pending_match
);
  localparam int ptr_bits = buffer_depth > 1 ? $clog2(buffer_depth) : 1;
  localparam int count_bits = $clog2(buffer_depth + 1);

  structures::wb_entry_t entries[buffer_depth];
  logic [buffer_depth-1:0] entry_valid;
  logic [ptr_bits-1:0] read_ptr;
  logic [ptr_bits-1:0] write_ptr;
  logic [count_bits-1:0] count;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(buffer_depth - 1)) ? '0 : ptr + 1'b1;  // Wraps at depth
  endfunction

  always_ff @(posedge global_bus) begin
    if (reset) begin
      read_ptr <= '0;
      write_ptr <= '0;
      count <= '0;
      entry_valid <= '0;
    end else begin
      if (push) begin
        write_ptr <= next_ptr(write_ptr);
        entry_valid[write_ptr] <= 1'b1;
      end
      if (pop) begin
        read_ptr <= next_ptr(read_ptr);
        entry_valid[read_ptr] <= 1'b0;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push with pop keeps occupancy
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    if (push) entries[write_ptr] <= push_entry;
  end

  // Any pending copy of the line blocks a fetch of it
  always_comb begin
    pending_match = 1'b0;
    for (int i = 0; i < buffer_depth; i++) begin
      if (entry_valid[i] && entries[i].address == lookup_address) pending_match = 1'b1;
    end
  end

  assign head = entries[read_ptr];
  assign not_empty = count != '0;
  assign full = count == count_bits'(buffer_depth);

endmodule

// ==== data_cache.sv ====
module data_cache #(
  parameter int sets = 8
) (
  input  logic                        global_bus,
  input  logic                        reset,
  input  structures::cache_req_t      cache_req,
  output structures::cache_rsp_t      cache_rsp,
  output structures::memory_req_t     memory_req,
  input  structures::memory_rsp_t     memory_rsp,
  output logic                        wb_push,
  output structures::wb_entry_t       wb_push_entry,
  output logic                        wb_pop,
  output logic [structures::xlen-1:0] wb_lookup_address,
  input  structures::wb_entry_t       wb_head,
  input  logic                        wb_not_empty,
  input  logic                        wb_full,
  input  logic                        wb_pending_match
);
  localparam int word_bits = $clog2(structures::line_words);
  localparam int offset_bits = word_bits + 2;  // Byte bits ignored
  localparam int set_bits = $clog2(sets);
  localparam int tag_bits = structures::xlen - set_bits - offset_bits;

  logic [tag_bits-1:0] tags[sets];
  structures::line_t lines[sets];
  structures::cache_state_e states[sets];

  logic [tag_bits-1:0] req_tag;
  logic [set_bits-1:0] req_set;
  logic [word_bits-1:0] req_word;
  logic [structures::xlen-1:0] line_address;

  logic request;
  logic hit;
  logic write_hit;
  logic victim_dirty;
  logic victim_push;

  structures::miss_state_e miss_state;
  structures::line_t fill_line;

  logic mem_read;
  logic mem_write;
  logic mem_busy;
  logic fetch_start;
  logic drain_start;
  logic [structures::xlen-1:0] mem_address;
  structures::line_t mem_line;

  // ##########################################################################
  // Lookup
  // ##########################################################################

  assign req_tag = cache_req.address[structures::xlen-1 -: tag_bits];
  assign req_set = cache_req.address[offset_bits +: set_bits];
  assign req_word = cache_req.address[2 +: word_bits];
  assign line_address = {cache_req.address[structures::xlen-1:offset_bits],
                         {offset_bits{1'b0}}};

  assign request = cache_req.read | cache_req.write;
  assign hit = request && states[req_set] != structures::invalid
               && tags[req_set] == req_tag;
  assign write_hit = hit && cache_req.write;
  assign victim_dirty = states[req_set] == structures::modified;

  assign cache_rsp = '{hit: hit, data: lines[req_set][req_word]};

  // ##########################################################################
  // Miss controller
  // ##########################################################################

  // Dirty victim leaves in the cycle the miss is seen
  assign victim_push = miss_state == structures::idle && request && !hit
                       && victim_dirty && !wb_full;

  always_ff @(posedge global_bus) begin
    if (reset) begin
      miss_state <= structures::idle;
    end else begin
      case (miss_state)
        structures::idle: begin
          if (request && !hit && (!victim_dirty || !wb_full)) begin
            miss_state <= structures::fetch;
          end
        end
        structures::fetch: begin
          if (mem_read && memory_rsp.ready) miss_state <= structures::install;
        end
        structures::install: miss_state <= structures::idle;
        default: miss_state <= structures::idle;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    if (mem_read && memory_rsp.ready) fill_line <= memory_rsp.line;
    if (miss_state == structures::install) begin
      tags[req_set] <= req_tag;
      lines[req_set] <= fill_line;
    end else if (write_hit) begin
      lines[req_set][req_word] <= cache_req.data;
    end
  end

  always_ff @(posedge global_bus) begin
    if (reset) begin
      for (int i = 0; i < sets; i++) states[i] <= structures::invalid;
    end else if (miss_state == structures::install) begin
      states[req_set] <= structures::valid;
    end else if (write_hit) begin
      states[req_set] <= structures::modified;
    end else if (victim_push) begin
      states[req_set] <= structures::invalid;  // Copy now lives in the buffer
    end
  end

  assign wb_push = victim_push;
  assign wb_push_entry = '{
    address: {tags[req_set], req_set, {offset_bits{1'b0}}},
    line: lines[req_set]
  };
  assign wb_lookup_address = line_address;

  // ##########################################################################
  // Memory port
  // ##########################################################################

  assign mem_busy = mem_read | mem_write;
  assign fetch_start = miss_state == structures::fetch && !mem_busy && !wb_pending_match;
  assign drain_start = !mem_busy && wb_not_empty && !fetch_start;  // Fetch wins the port

  always_ff @(posedge global_bus) begin
    if (reset) begin
      mem_read <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      if (fetch_start) mem_read <= 1'b1;
      else if (mem_read && memory_rsp.ready) mem_read <= 1'b0;
      if (drain_start) mem_write <= 1'b1;
      else if (mem_write && memory_rsp.done) mem_write <= 1'b0;
    end
  end

  always_ff @(posedge global_bus) begin
    if (fetch_start) begin
      mem_address <= line_address;
    end else if (drain_start) begin
      mem_address <= wb_head.address;
      mem_line <= wb_head.line;
    end
  end

  assign memory_req = '{
    read: mem_read,
    write: mem_write,
    address: mem_address,
    line: mem_line
  };

  assign wb_pop = mem_write && memory_rsp.done;  // Head is in memory now

endmodule

// ==== main_memory.sv ====
module main_memory #(
  parameter int memory_latency = 3,
  parameter int memory_lines = 64
) (
  input  logic                    global_bus,
  input  logic                    reset,
  input  structures::memory_req_t memory_req,
  output structures::memory_rsp_t memory_rsp
);
  localparam int offset_bits = $clog2(structures::line_words) + 2;
  localparam int index_bits = $clog2(memory_lines);
  localparam int count_bits = $clog2(memory_latency + 1);

  structures::line_t storage[memory_lines];

  logic [index_bits-1:0] index;
  logic [count_bits-1:0] count;
  logic busy;
  logic op_write;
  logic accept;
  logic finish;

  // Address is held stable for the whole operation
  assign index = memory_req.address[offset_bits +: index_bits];

  assign accept = !busy && (memory_req.read || memory_req.write);
  assign finish = busy && count == '0;

  // ##########################################################################
  // Operation timer and storage
  // ##########################################################################

  always_ff @(posedge global_bus) begin
    if (reset) begin
      busy <= 1'b0;
      op_write <= 1'b0;
      count <= '0;
      for (int i = 0; i < memory_lines; i++) storage[i] <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      op_write <= memory_req.write;
      count <= count_bits'(memory_latency - 1);
    end else if (finish) begin
      busy <= 1'b0;
      if (op_write) storage[index] <= memory_req.line;  // Stored at done
    end else if (busy) begin
      count <= count - 1'b1;
    end
  end

  assign memory_rsp = '{
    ready: finish && !op_write,
    done: finish && op_write,
    line: storage[index]
  };

endmodule

// ==== cache_subsystem.sv ====
module cache_subsystem #(
  parameter int sets = 8,
  parameter int buffer_depth = 4,
  parameter int memory_latency = 3,
  parameter int memory_lines = 64
) (
  input  logic                   global_bus,
  input  logic                   reset,
  input  structures::cache_req_t cache_req,
  output structures::cache_rsp_t cache_rsp
);
  structures::memory_req_t memory_req;
  structures::memory_rsp_t memory_rsp;
  structures::wb_entry_t wb_push_entry;
  structures::wb_entry_t wb_head;
  logic [structures::xlen-1:0] wb_lookup_address;
  logic wb_push;
  logic wb_pop;
  logic wb_not_empty;
  logic wb_full;
  logic wb_pending_match;

  data_cache #(
    .sets(sets)
  ) data_cache_i (
    .global_bus       (global_bus),
    .reset            (reset),
    .cache_req        (cache_req),
    .cache_rsp        (cache_rsp),
    .memory_req       (memory_req),
    .memory_rsp       (memory_rsp),
    .wb_push          (wb_push),
    .wb_push_entry    (wb_push_entry),
    .wb_pop           (wb_pop),
    .wb_lookup_address(wb_lookup_address),
    .wb_head          (wb_head),
    .wb_not_empty     (wb_not_empty),
    .wb_full          (wb_full),
    .wb_pending_match (wb_pending_match)
  );

  write_buffer #(
    .buffer_depth(buffer_depth)
  ) write_buffer_i (
    .global_bus    (global_bus),
    .reset         (reset),
    .push          (wb_push),
    .push_entry    (wb_push_entry),
    .pop           (wb_pop),
    .lookup_address(wb_lookup_address),
    .head          (wb_head),
    .not_empty     (wb_not_empty),
    .full          (wb_full),
    .pending_match (wb_pending_match)
  );

  main_memory #(
    .memory_latency(memory_latency),
    .memory_lines  (memory_lines)
  ) main_memory_i (
    .global_bus(global_bus),
    .reset     (reset),
    .memory_req(memory_req),
    .memory_rsp(memory_rsp)
  );

endmodule

// ==== tb_cache_subsystem.sv ====
module tb_cache_subsystem;

  localparam int sets = 8;
  localparam int memory_lines = 64;
  localparam int line_bytes = structures::line_words * 4;
  localparam int words_total = memory_lines * structures::line_words;
  localparam int random_ops = 2000;
  localparam int total_ops = 8 + 5 + 16 + 32 + random_ops;
  localparam int timeout_cycles = 60 * total_ops;

  logic global_bus;
  logic reset;
  structures::cache_req_t cache_req;
  structures::cache_rsp_t cache_rsp;

  logic [structures::xlen-1:0] model_mem[logic [structures::xlen-1:0]];  // Keyed by word address
  logic [structures::xlen-1:0] expected;
  int cycle_count = 0;
  int wait_cycles = 0;

  cache_subsystem dut_i (
    .global_bus(global_bus),
    .reset     (reset),
    .cache_req (cache_req),
    .cache_rsp (cache_rsp)
  );

  initial global_bus = 1'b0;
  always #10 global_bus = ~global_bus;

  // ##########################################################################
  // Reference model
  // ##########################################################################

  function automatic logic [structures::xlen-1:0] model_read(
    input logic [structures::xlen-1:0] address
  );
    logic [structures::xlen-1:0] key;
    key = address >> 2;  // Byte bits ignored
    if (model_mem.exists(key)) return model_mem[key];
    return '0;  // Memory starts cleared
  endfunction

  function automatic void model_write(
    input logic [structures::xlen-1:0] address,
    input logic [structures::xlen-1:0] data
  );
    model_mem[address >> 2] = data;
  endfunction

  function automatic logic [structures::xlen-1:0] make_address(
    input int tag,
    input int set,
    input int word
  );
    return 32'(tag * sets * line_bytes + set * line_bytes + word * 4);
  endfunction

  // ##########################################################################
  // CPU side driver
  // ##########################################################################

  task automatic issue_request(
    input logic                        is_write,
    input logic [structures::xlen-1:0] address,
    input logic [structures::xlen-1:0] data
  );
    cache_req = '{read: !is_write, write: is_write, address: address, data: data};
    wait_cycles = 0;
    do begin
      @(negedge global_bus);
      wait_cycles++;
    end while (!cache_rsp.hit);  // Held until hit
    @(posedge global_bus);
    #2;
  endtask

  task automatic read_word(input logic [structures::xlen-1:0] address);
    issue_request(1'b0, address, '0);
  endtask

  task automatic write_word(
    input logic [structures::xlen-1:0] address,
    input logic [structures::xlen-1:0] data
  );
    issue_request(1'b1, address, data);
  endtask

  // Completion is the hit cycle, sampled mid period
  always @(negedge global_bus) begin
    if (!reset && cache_rsp.hit) begin
      if (cache_req.write) begin
        model_write(cache_req.address, cache_req.data);
      end else begin
        expected = model_read(cache_req.address);
        assert (cache_rsp.data == expected) else begin
          $display("FAILED cache_rsp.data at address %h: expected %h, actual %h",
                   cache_req.address, expected, cache_rsp.data);
          $display("Test failures found");
          $fatal(1);
        end
      end
    end
  end

  always @(posedge global_bus) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // ##########################################################################
  // Stimulus
  // ##########################################################################

  initial begin
    logic [structures::xlen-1:0] address;
    void'($urandom(5028));
    reset = 1'b1;
    cache_req = '0;
    repeat (5) @(posedge global_bus);
    #2;
    reset = 1'b0;

    for (int s = 0; s < sets; s++) read_word(make_address(s, s, s % 4));  // Cold reads

    address = make_address(2, 0, 1);
    write_word(address, $urandom);
    read_word(address);
    assert (wait_cycles == 1) else begin
      $display("Read at address %h did not hit in its request cycle", address);
      $display("Test failures found");
      $fatal(1);
    end
    for (int w = 0; w < structures::line_words; w++) begin
      if (w != 1) read_word(make_address(2, 0, w));  // Rest of the line
    end

    for (int t = 0; t < 8; t++) write_word(make_address(t, 3, t % 4), $urandom);
    for (int t = 0; t < 8; t++) read_word(make_address(t, 3, t % 4));

    // Two tags in one set, each miss refetches the line the previous write evicted
    for (int k = 0; k < 24; k++) write_word(make_address(k % 2, 6, k % 4), $urandom);
    for (int t = 0; t < 2; t++) begin
      for (int w = 0; w < structures::line_words; w++) read_word(make_address(t, 6, w));
    end

    for (int i = 0; i < random_ops; i++) begin
      address = 32'($urandom_range(words_total - 1)) << 2;
      if ($urandom_range(99) < 60) read_word(address);
      else write_word(address, $urandom);
    end

    cache_req = '0;
    repeat (2) @(posedge global_bus);
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== src.f ====
structures.sv
write_buffer.sv
data_cache.sv
main_memory.sv
cache_subsystem.sv
tb_cache_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the data cache subsystem

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_cache_subsystem
LINT_TOP  ?= cache_subsystem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard *.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
